// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --assert -Wno-fatal
TOP       := udp_rx_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := >>> PASS

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== src.f ====
+incdir+include
verilog/udp_rx_pkg.sv
verilog/hdr_strip.sv
verilog/udp_port_filter.sv
verilog/udp_rx_top.sv
verification/udp_rx_tb.sv

// ==== include/udp_frame_build.svh ====
`ifndef UDP_FRAME_BUILD_SVH
`define UDP_FRAME_BUILD_SVH

// Frames as byte queues with index 0 as the first byte on the wire
typedef logic [7:0] byte_q_t[$];

localparam int FRAME_HDR_BYTES =
    ($bits(eth_hdr_t) + $bits(ipv4_hdr_t) + $bits(udp_hdr_t)) / 8;

function automatic eth_hdr_t make_eth_hdr(input mac_addr_t dst_mac);
    eth_hdr_t h;
    h.dst_mac   = dst_mac;
    h.src_mac   = 48'h02_a0_b0_c0_d0_e0;
    h.ethertype = 16'h0800;
    return h;
endfunction

// Plain IPv4 header with the checksum left at zero
function automatic ipv4_hdr_t make_ip_hdr(input ip_addr_t src_ip, input ip_addr_t dst_ip,
                                          input int payload_len);
    ipv4_hdr_t h;
    h.version           = 4'd4;
    h.ihl               = 4'd5;
    h.dscp_ecn          = 8'h00;
    h.total_length      = 16'(20 + 8 + payload_len);
    h.identification    = 16'h4d2e;
    h.flags_frag_offset = 16'h4000;
    h.ttl               = 8'd64;
    h.protocol          = 8'd17;
    h.hdr_checksum      = 16'h0000;
    h.src_ip            = src_ip;
    h.dst_ip            = dst_ip;
    return h;
endfunction

// UDP length covers the 8 header bytes
function automatic udp_hdr_t make_udp_hdr(input logic [15:0] dst_port, input int payload_len);
    udp_hdr_t h;
    h.src_port = 16'd40000;
    h.dst_port = dst_port;
    h.length   = 16'(8 + payload_len);
    h.checksum = 16'h0000;
    return h;
endfunction

function automatic byte_q_t make_payload(input int len, input logic [7:0] first);
    byte_q_t q;
    int      i;
    for (i = 0; i < len; i++) begin
        q.push_back(first + 8'(i * 37));
    end
    return q;
endfunction

function automatic byte_q_t build_frame(input eth_hdr_t eth, input ipv4_hdr_t ip,
                                        input udp_hdr_t udp, input byte_q_t payload);
    logic [FRAME_HDR_BYTES*8-1:0] hdr_bits;
    byte_q_t                      frame;
    int                           i;
    hdr_bits = {eth, ip, udp};
    for (i = FRAME_HDR_BYTES - 1; i >= 0; i--) begin
        frame.push_back(hdr_bits[i*8 +: 8]);
    end
    for (i = 0; i < payload.size(); i++) begin
        frame.push_back(payload[i]);
    end
    return frame;
endfunction

`endif

// ==== verification/udp_rx_tb.sv ====
`timescale 1ns/10ps

module udp_rx_tb import udp_rx_pkg::*; ();

    localparam mac_addr_t   LOCAL_MAC  = 48'h11_22_33_44_55_66;
    localparam ip_addr_t    LOCAL_IP   = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam logic [15:0] LOCAL_PORT = 16'd1234;
    localparam int          CLK_PERIOD = 4;

    logic       clk;
    logic       rst;
    logic       in_valid;
    logic       in_ready;
    byte_beat_t in_beat;
    logic       meta_valid;
    logic       meta_ready;
    udp_meta_t  meta;
    logic       out_valid;
    logic       out_ready;
    byte_beat_t out_beat;

    int         seed = 25768;
    bit         random_ready;
    udp_meta_t  exp_meta[$];
    udp_meta_t  got_meta[$];
    byte_beat_t exp_beats[$];
    byte_beat_t got_beats[$];

    `include "udp_frame_build.svh"

    // Twelve full frames and two runts over all tests
    localparam int PAYLOAD_BYTES   = 102;
    localparam int RUNT_BYTES      = 24;
    localparam int PROBE_BYTES     = 1;
    localparam int TOTAL_BYTES     = 12 * FRAME_HDR_BYTES + PAYLOAD_BYTES + RUNT_BYTES
                                     + PROBE_BYTES;
    localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 20 + 500;

    udp_rx_top #(
        .LOCAL_MAC (LOCAL_MAC),
        .LOCAL_IP  (LOCAL_IP),
        .UDP_PORT  (LOCAL_PORT)
    ) dut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_beat    (in_beat),
        .meta_valid (meta_valid),
        .meta_ready (meta_ready),
        .meta       (meta),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_beat   (out_beat)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_now($sformatf("Watchdog expired after %0d cycles, traffic stopped moving",
                           WATCHDOG_CYCLES));
    end

    // User side ready signals
    initial begin
        logic [31:0] rnd;
        meta_ready = 1'b1;
        out_ready  = 1'b1;
        forever begin
            @(posedge clk);
            rnd = $random(seed);
            #1;
            if (random_ready) begin
                meta_ready = rnd[0];
                out_ready  = rnd[1];
            end else begin
                meta_ready = 1'b1;
                out_ready  = 1'b1;
            end
        end
    end

    // Outputs are settled at the falling edge and hold until the next rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (meta_valid && meta_ready) begin
                got_meta.push_back(meta);
            end
            if (out_valid && out_ready) begin
                got_beats.push_back(out_beat);
            end
        end
    end

    task automatic fail_now(input string what);
        $display(">>> FAIL");
        $display("%s", what);
        $fatal(1);
    endtask

    function automatic byte_q_t matching_frame(input ip_addr_t src_ip, input logic [15:0] port,
                                               input byte_q_t payload);
        return build_frame(make_eth_hdr(LOCAL_MAC),
                           make_ip_hdr(src_ip, LOCAL_IP, payload.size()),
                           make_udp_hdr(port, payload.size()), payload);
    endfunction

    // Sender IP and payload size, then payload bytes with last on the final one
    function automatic void expect_frame(input ip_addr_t src_ip, input byte_q_t payload);
        udp_meta_t  m;
        byte_beat_t b;
        int         i;
        m.src_ip = src_ip;
        m.length = 16'(payload.size());
        exp_meta.push_back(m);
        for (i = 0; i < payload.size(); i++) begin
            b.data = payload[i];
            b.last = (i == payload.size() - 1);
            exp_beats.push_back(b);
        end
    endfunction

    task automatic drive_frame(input byte_q_t frame, input bit gaps);
        int          i;
        logic [31:0] rnd;
        for (i = 0; i < frame.size(); i++) begin
            if (gaps) begin
                rnd      = $random(seed);
                in_valid = 1'b0;
                repeat (rnd[1:0]) begin
                    @(posedge clk);
                    #1;
                end
            end
            in_valid     = 1'b1;
            in_beat.data = frame[i];
            in_beat.last = (i == frame.size() - 1);
            do begin
                @(negedge clk);
            end while (!in_ready);
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    task automatic check_outputs();
        int i;
        // A few idle cycles so late beats get caught
        repeat (5) @(posedge clk);
        #1;
        assert (got_meta.size() == exp_meta.size())
        else fail_now($sformatf("Wrong number of meta headers at %0t ns: expected %0d, saw %0d",
                                $time, exp_meta.size(), got_meta.size()));
        assert (got_beats.size() == exp_beats.size())
        else fail_now($sformatf("Wrong number of payload bytes at %0t ns: expected %0d, saw %0d",
                                $time, exp_beats.size(), got_beats.size()));
        for (i = 0; i < exp_meta.size(); i++) begin
            assert (got_meta[i].src_ip == exp_meta[i].src_ip)
            else fail_now($sformatf("Error at %0t ns: meta.src_ip expected %h, got %h",
                                    $time, exp_meta[i].src_ip, got_meta[i].src_ip));
            assert (got_meta[i].length == exp_meta[i].length)
            else fail_now($sformatf("Error at %0t ns: meta.length expected %0d, got %0d",
                                    $time, exp_meta[i].length, got_meta[i].length));
        end
        for (i = 0; i < exp_beats.size(); i++) begin
            assert (got_beats[i].data == exp_beats[i].data)
            else fail_now($sformatf("Error at %0t ns: out_beat.data[%0d] expected %h, got %h",
                                    $time, i, exp_beats[i].data, got_beats[i].data));
            assert (got_beats[i].last == exp_beats[i].last)
            else fail_now($sformatf("Error at %0t ns: out_beat.last[%0d] expected %b, got %b",
                                    $time, i, exp_beats[i].last, got_beats[i].last));
        end
        exp_meta.delete();
        got_meta.delete();
        exp_beats.delete();
        got_beats.delete();
    endtask

    task automatic idle_after_reset();
        // A lone byte with last set is a runt and must leave no trace
        in_valid     = 1'b1;
        in_beat.data = 8'hff;
        in_beat.last = 1'b1;
        @(negedge clk);
        assert (meta_valid == 1'b0)
        else fail_now($sformatf("Error at %0t ns: meta_valid expected 0, got %b",
                                $time, meta_valid));
        assert (out_valid == 1'b0)
        else fail_now($sformatf("Error at %0t ns: out_valid expected 0, got %b",
                                $time, out_valid));
        assert (in_ready == 1'b1)
        else fail_now($sformatf("Error at %0t ns: in_ready expected 1, got %b",
                                $time, in_ready));
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic single_match();
        byte_q_t  payload;
        ip_addr_t peer;
        peer    = {8'd10, 8'd0, 8'd0, 8'd5};
        payload = make_payload(10, 8'h30);
        expect_frame(peer, payload);
        drive_frame(matching_frame(peer, LOCAL_PORT, payload), 1'b0);
        check_outputs();
    endtask

    task automatic wrong_port_then_match();
        byte_q_t  payload;
        ip_addr_t peer;
        peer    = {8'd10, 8'd0, 8'd0, 8'd6};
        payload = make_payload(8, 8'h51);
        drive_frame(matching_frame(peer, LOCAL_PORT + 16'd1, payload), 1'b0);
        payload = make_payload(12, 8'h62);
        expect_frame(peer, payload);
        drive_frame(matching_frame(peer, LOCAL_PORT, payload), 1'b0);
        check_outputs();
    endtask

    task automatic single_faults_dropped();
        eth_hdr_t  eth;
        ipv4_hdr_t ip;
        udp_hdr_t  udp;
        byte_q_t   payload;
        int        fault;
        payload = make_payload(6, 8'h90);
        for (fault = 0; fault < 5; fault++) begin
            eth = make_eth_hdr(LOCAL_MAC);
            ip  = make_ip_hdr({8'd10, 8'd0, 8'd0, 8'd7}, LOCAL_IP, payload.size());
            udp = make_udp_hdr(LOCAL_PORT, payload.size());
            case (fault)
                0:       eth.dst_mac = 48'h11_22_33_44_55_67;
                1:       eth.ethertype = 16'h86dd;
                2:       ip.ihl = 4'd6;
                3:       ip.protocol = 8'd6;
                default: ip.dst_ip = {8'd192, 8'd168, 8'd1, 8'd129};
            endcase
            drive_frame(build_frame(eth, ip, udp, payload), 1'b0);
        end
        check_outputs();
    endtask

    task automatic backpressure_frames();
        byte_q_t  payload;
        ip_addr_t peer;
        int       n;
        int       sizes[3] = '{5, 17, 9};
        random_ready = 1'b1;
        for (n = 0; n < 3; n++) begin
            peer    = {8'd172, 8'd16, 8'd0, 8'(n + 1)};
            payload = make_payload(sizes[n], 8'(8'hc0 + n));
            expect_frame(peer, payload);
            drive_frame(matching_frame(peer, LOCAL_PORT, payload), 1'b1);
        end
        random_ready = 1'b0;
        check_outputs();
    endtask

    task automatic runt_then_match();
        byte_q_t  payload;
        byte_q_t  runt;
        ip_addr_t peer;
        peer    = {8'd10, 8'd0, 8'd0, 8'd9};
        payload = make_payload(6, 8'h11);
        runt    = matching_frame(peer, LOCAL_PORT, payload);
        // Cut inside the IP header
        runt    = runt[0:RUNT_BYTES-1];
        drive_frame(runt, 1'b0);
        payload = make_payload(11, 8'h24);
        expect_frame(peer, payload);
        drive_frame(matching_frame(peer, LOCAL_PORT, payload), 1'b0);
        check_outputs();
    endtask

    initial begin
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_beat      = '0;
        random_ready = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        idle_after_reset();
        single_match();
        wrong_port_then_match();
        single_faults_dropped();
        backpressure_frames();
        runt_then_match();
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== verilog/hdr_strip.sv ====
`timescale 1ns/10ps

module hdr_strip import udp_rx_pkg::*; #(
    parameter type hdr_t = eth_hdr_t
) (
    input  logic       clk,
    input  logic       rst,

    input  logic       in_valid,
    output logic       in_ready,
    input  byte_beat_t in_beat,

    output hdr_t       hdr,
    output logic       hdr_done,

    output logic       out_valid,
    input  logic       out_ready,
    output byte_beat_t out_beat
);

    localparam int HDR_W     = $bits(hdr_t);
    localparam int HDR_BYTES = HDR_W / 8;
    localparam int CNT_W     = $clog2(HDR_BYTES);

    logic [CNT_W-1:0] byte_cnt;
    logic [HDR_W-1:0] hdr_q;
    logic             payload_mode;
    logic             in_fire;
    logic             last_hdr_byte;

    assign in_fire       = in_valid && in_ready;
    assign last_hdr_byte = (byte_cnt == CNT_W'(HDR_BYTES - 1));

    // Header bytes are always taken, payload follows downstream ready
    assign in_ready  = payload_mode ? out_ready : 1'b1;
    assign out_valid = payload_mode && in_valid;
    assign out_beat  = in_beat;

    assign hdr      = hdr_t'(hdr_q);
    assign hdr_done = payload_mode;

    always_ff @(posedge clk) begin
        if (rst) begin
            payload_mode <= 1'b0;
            byte_cnt     <= '0;
        end else if (in_fire) begin
            if (payload_mode) begin
                if (in_beat.last) begin
                    payload_mode <= 1'b0;
                end
            end else if (in_beat.last) begin
                // Runt frame that ends before the header is complete
                byte_cnt <= '0;
            end else if (last_hdr_byte) begin
                byte_cnt     <= '0;
                payload_mode <= 1'b1;
            end else begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    // Shift in MSB first so the struct lines up with wire order
    always_ff @(posedge clk) begin
        if (in_fire && !payload_mode) begin
            hdr_q <= {hdr_q[HDR_W-9:0], in_beat.data};
        end
    end

endmodule

// ==== verilog/udp_port_filter.sv ====
`timescale 1ns/10ps

module udp_port_filter import udp_rx_pkg::*; #(
    parameter mac_addr_t   LOCAL_MAC = 48'h11_22_33_44_55_66,
    parameter ip_addr_t    LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128},
    parameter logic [15:0] UDP_PORT  = 16'd1234
) (
    input  logic       clk,
    input  logic       rst,

    input  eth_hdr_t   eth_hdr,
    input  ipv4_hdr_t  ip_hdr,
    input  udp_hdr_t   udp_hdr,
    input  logic       hdr_done,

    input  logic       in_valid,
    output logic       in_ready,
    input  byte_beat_t in_beat,

    output logic       meta_valid,
    input  logic       meta_ready,
    output udp_meta_t  meta,

    output logic       out_valid,
    input  logic       out_ready,
    output byte_beat_t out_beat
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_META,
        ST_FWD,
        ST_DROP
    } state_t;

    state_t    state;
    udp_meta_t meta_q;
    udp_meta_t meta_next;
    logic      frame_match;
    logic      in_last_fire;

    // All acceptance rules in one place
    always_comb begin
        frame_match = (eth_hdr.dst_mac == LOCAL_MAC)
                   && (eth_hdr.ethertype == ETHERTYPE_IPV4)
                   && (ip_hdr.version == 4'd4)
                   && (ip_hdr.ihl == 4'd5)
                   && (ip_hdr.protocol == IP_PROTO_UDP)
                   && (ip_hdr.dst_ip == LOCAL_IP)
                   && (udp_hdr.dst_port == UDP_PORT);
    end

    always_comb begin
        meta_next.src_ip = ip_hdr.src_ip;
        meta_next.length = udp_hdr.length - 16'(UDP_HDR_BYTES);
    end

    assign in_last_fire = in_valid && in_ready && in_beat.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_done) begin
                        state <= frame_match ? ST_META : ST_DROP;
                    end
                end
                ST_META: begin
                    if (meta_ready) begin
                        state <= ST_FWD;
                    end
                end
                ST_FWD: begin
                    if (in_last_fire) begin
                        state <= ST_IDLE;
                    end
                end
                ST_DROP: begin
                    if (in_last_fire) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Captured once per frame while the decision is made
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && hdr_done) begin
            meta_q <= meta_next;
        end
    end

    assign meta       = meta_q;
    assign meta_valid = (state == ST_META);

    // Payload is held back until the meta has gone out
    always_comb begin
        case (state)
            ST_FWD:  in_ready = out_ready;
            ST_DROP: in_ready = 1'b1;
            default: in_ready = 1'b0;
        endcase
    end

    assign out_valid = (state == ST_FWD) && in_valid;
    assign out_beat  = in_beat;

endmodule

// ==== verilog/udp_rx_pkg.sv ====
package udp_rx_pkg;

    // One byte of the frame stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } byte_beat_t;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;

    // Header structs hold the first wire byte in the top bits

    typedef struct packed {
        mac_addr_t   dst_mac;
        mac_addr_t   src_mac;
        logic [15:0] ethertype;
    } eth_hdr_t;

    // IPv4 without options
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [7:0]  dscp_ecn;
        logic [15:0] total_length;
        logic [15:0] identification;
        logic [15:0] flags_frag_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] hdr_checksum;
        ip_addr_t    src_ip;
        ip_addr_t    dst_ip;
    } ipv4_hdr_t;

    typedef struct packed {
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_hdr_t;

    // Header handed to the user ahead of the payload
    typedef struct packed {
        ip_addr_t    src_ip;
        logic [15:0] length;
    } udp_meta_t;

    parameter logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    parameter logic [7:0]  IP_PROTO_UDP   = 8'd17;

    // UDP length field counts its own header too
    parameter int UDP_HDR_BYTES = 8;

endpackage

// ==== verilog/udp_rx_top.sv ====
`timescale 1ns/10ps

module udp_rx_top import udp_rx_pkg::*; #(
    parameter mac_addr_t   LOCAL_MAC = 48'h11_22_33_44_55_66,
    parameter ip_addr_t    LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128},
    parameter logic [15:0] UDP_PORT  = 16'd1234
) (
    input  logic       clk,
    input  logic       rst,

    input  logic       in_valid,
    output logic       in_ready,
    input  byte_beat_t in_beat,

    output logic       meta_valid,
    input  logic       meta_ready,
    output udp_meta_t  meta,

    output logic       out_valid,
    input  logic       out_ready,
    output byte_beat_t out_beat
);

    eth_hdr_t   eth_hdr;
    ipv4_hdr_t  ip_hdr;
    udp_hdr_t   udp_hdr;
    logic       udp_hdr_done;

    // Payload of each stage feeds the next
    logic       eth_pay_valid;
    logic       eth_pay_ready;
    byte_beat_t eth_pay_beat;
    logic       ip_pay_valid;
    logic       ip_pay_ready;
    byte_beat_t ip_pay_beat;
    logic       udp_pay_valid;
    logic       udp_pay_ready;
    byte_beat_t udp_pay_beat;

    hdr_strip #(.hdr_t(eth_hdr_t)) eth_strip (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .hdr       (eth_hdr),
        .hdr_done  (),
        .out_valid (eth_pay_valid),
        .out_ready (eth_pay_ready),
        .out_beat  (eth_pay_beat)
    );

    hdr_strip #(.hdr_t(ipv4_hdr_t)) ip_strip (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (eth_pay_valid),
        .in_ready  (eth_pay_ready),
        .in_beat   (eth_pay_beat),
        .hdr       (ip_hdr),
        .hdr_done  (),
        .out_valid (ip_pay_valid),
        .out_ready (ip_pay_ready),
        .out_beat  (ip_pay_beat)
    );

    hdr_strip #(.hdr_t(udp_hdr_t)) udp_strip (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (ip_pay_valid),
        .in_ready  (ip_pay_ready),
        .in_beat   (ip_pay_beat),
        .hdr       (udp_hdr),
        .hdr_done  (udp_hdr_done),
        .out_valid (udp_pay_valid),
        .out_ready (udp_pay_ready),
        .out_beat  (udp_pay_beat)
    );

    udp_port_filter #(
        .LOCAL_MAC (LOCAL_MAC),
        .LOCAL_IP  (LOCAL_IP),
        .UDP_PORT  (UDP_PORT)
    ) filter (
        .clk        (clk),
        .rst        (rst),
        .eth_hdr    (eth_hdr),
        .ip_hdr     (ip_hdr),
        .udp_hdr    (udp_hdr),
        .hdr_done   (udp_hdr_done),
        .in_valid   (udp_pay_valid),
        .in_ready   (udp_pay_ready),
        .in_beat    (udp_pay_beat),
        .meta_valid (meta_valid),
        .meta_ready (meta_ready),
        .meta       (meta),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_beat   (out_beat)
    );

endmodule
